//--- logic/ahb_pkg.sv
// AHB-lite subset: single transfers only, no bursts, no HPROT
// HRESP carries only OKAY and ERROR

package ahb_pkg;

	// transfer type, standard AHB encoding
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// RETRY and SPLIT never produced
	typedef enum logic {
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_t;

	// transfer size, nothing wider than a word
	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_t;

	// slave data phase sequencing
	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_DATA = 2'b01,
		ST_ERR1 = 2'b10,
		ST_ERR2 = 2'b11
	} ctrl_state_t;

endpackage

//--- logic/ahb_slave_ctrl.sv
// single slave, so HREADY is generated here and never taken as an input
// timer and gpio accept word transfers only, anything else gets ERROR
`timescale 1ns/1ps

module ahb_slave_ctrl
	import ahb_pkg::*;
	import soc_map_pkg::*;
(
	input  logic                      HCLK,
	input  logic                      rst,
	input  logic                      HSEL,
	input  htrans_t                   HTRANS,
	input  logic                      HWRITE,
	input  hsize_t                    HSIZE,
	input  logic [ADDR_WIDTH-1:0]     HADDR,
	output logic                      HREADY,
	output hresp_t                    HRESP,
	output logic [DATA_WIDTH-1:0]     HRDATA,
	output logic                      dtcm_wr_en,
	output logic [STRB_WIDTH-1:0]     dtcm_byte_strb,
	output logic                      timer_wr_en,
	output logic                      gpio_wr_en,
	output logic [DTCM_IDX_WIDTH-1:0] reg_word,
	input  logic [DATA_WIDTH-1:0]     dtcm_rdata,
	input  logic [DATA_WIDTH-1:0]     timer_rdata,
	input  logic [DATA_WIDTH-1:0]     gpio_rdata
);

	function automatic region_t decode_region(input logic [ADDR_WIDTH-1:0] addr);
		logic [ADDR_WIDTH-1:0] dtcm_mask;
		logic [ADDR_WIDTH-1:0] reg_mask;
		dtcm_mask = ~(ADDR_WIDTH'(DTCM_WORDS * STRB_WIDTH) - 1'b1);
		reg_mask = ~(REGION_SPAN - 1'b1);
		if ((addr & dtcm_mask) == DTCM_BASE)
			return REG_DTCM;
		else if ((addr & reg_mask) == TIMER_BASE)
			return REG_TIMER;
		else if ((addr & reg_mask) == GPIO_BASE)
			return REG_GPIO;
		else
			return REG_NONE;
	endfunction

	// byte lanes touched by a little endian transfer
	function automatic logic [STRB_WIDTH-1:0] lane_strb(input hsize_t size,
			input logic [1:0] lsb);
		case (size)
			BYTE:    return STRB_WIDTH'(1) << lsb;
			HALF:    return STRB_WIDTH'(3) << {lsb[1], 1'b0};
			default: return '1;
		endcase
	endfunction

	ctrl_state_t               state;
	ctrl_state_t               state_nxt;
	region_t                   region_d;
	region_t                   region_q;
	logic                      wr_q;
	logic [STRB_WIDTH-1:0]     strb_q;
	logic [DTCM_IDX_WIDTH-1:0] word_q;
	logic [DTCM_IDX_WIDTH+1:0] addr_ofs;
	logic                      accept;
	logic                      misalign;
	logic                      sub_word_reg;
	logic                      ofs_range;
	logic                      err_d;
	logic                      data_wr;

	// address phase, ignored while the first error cycle holds HREADY low
	assign accept = HSEL && (HTRANS == NONSEQ || HTRANS == SEQ) && HREADY;
	assign region_d = decode_region(HADDR);
	assign addr_ofs = HADDR[DTCM_IDX_WIDTH+1:0];

	assign misalign = (HSIZE == HALF && HADDR[0]) ||
		(HSIZE == WORD && HADDR[1:0] != 2'b00) ||
		!(HSIZE inside {BYTE, HALF, WORD});
	assign sub_word_reg = (region_d == REG_TIMER || region_d == REG_GPIO) &&
		HSIZE != WORD;
	// holes past the last implemented register
	assign ofs_range = (region_d == REG_TIMER && addr_ofs > MTIMECMP_HI) ||
		(region_d == REG_GPIO && addr_ofs > GPIO_IN_OFS);
	assign err_d = region_d == REG_NONE || misalign || sub_word_reg || ofs_range;

	always_comb begin
		state_nxt = ST_IDLE;
		if (state == ST_ERR1)
			state_nxt = ST_ERR2;
		else if (accept)
			state_nxt = err_d ? ST_ERR1 : ST_DATA;
	end

	always_ff @(posedge HCLK) begin
		if (rst) begin
			state <= ST_IDLE;
			region_q <= REG_NONE;
			wr_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (accept) begin
				region_q <= region_d;
				wr_q <= HWRITE;
			end
		end
	end

	always_ff @(posedge HCLK) begin
		if (accept) begin
			word_q <= HADDR[DTCM_IDX_WIDTH+1:2];
			strb_q <= lane_strb(HSIZE, HADDR[1:0]);
		end
	end

	assign HREADY = (state != ST_ERR1);
	assign HRESP = (state == ST_ERR1 || state == ST_ERR2) ? ERROR : OKAY;

	// enables only in an OKAY data phase
	assign data_wr = (state == ST_DATA) && wr_q;
	assign dtcm_wr_en = data_wr && region_q == REG_DTCM;
	assign timer_wr_en = data_wr && region_q == REG_TIMER;
	assign gpio_wr_en = data_wr && region_q == REG_GPIO;
	assign dtcm_byte_strb = strb_q;
	assign reg_word = word_q;

	always_comb begin
		case (region_q)
			REG_DTCM:  HRDATA = dtcm_rdata;
			REG_TIMER: HRDATA = timer_rdata;
			REG_GPIO:  HRDATA = gpio_rdata;
			default:   HRDATA = '0;
		endcase
	end

	a_err_two_cycle: assert property (@(posedge HCLK) disable iff (rst)
		(HRESP == ERROR && !HREADY) |=> (HRESP == ERROR && HREADY))
		else $error("error response not completed in its second cycle");

	a_one_wr_en: assert property (@(posedge HCLK) disable iff (rst)
		$onehot0({dtcm_wr_en, timer_wr_en, gpio_wr_en}))
		else $error("more than one target write enable");

endmodule

//--- logic/core_timer.sv
// machine timer, mtime counts HCLK cycles
// halves are written one at a time, a carry between writes is not guarded
`timescale 1ns/1ps

module core_timer
	import soc_map_pkg::*;
(
	input  logic                      HCLK,
	input  logic                      rst,
	input  logic                      timer_wr_en,
	input  logic [DTCM_IDX_WIDTH-1:0] reg_word,
	input  logic [DATA_WIDTH-1:0]     HWDATA,
	output logic [DATA_WIDTH-1:0]     timer_rdata,
	output logic                      core_timer_int
);

	logic [2*DATA_WIDTH-1:0]   mtime;
	logic [2*DATA_WIDTH-1:0]   mtimecmp;
	logic [DTCM_IDX_WIDTH+1:0] ofs;
	logic                      mtime_wr;

	assign ofs = {reg_word, 2'b00};
	assign mtime_wr = timer_wr_en && (ofs == MTIME_LO || ofs == MTIME_HI);

	// no increment in the cycle mtime is written
	always_ff @(posedge HCLK) begin
		if (rst) begin
			mtime <= '0;
		end else if (mtime_wr) begin
			if (ofs == MTIME_LO)
				mtime[DATA_WIDTH-1:0] <= HWDATA;
			else
				mtime[2*DATA_WIDTH-1:DATA_WIDTH] <= HWDATA;
		end else begin
			mtime <= mtime + 1'b1;
		end
	end

	always_ff @(posedge HCLK) begin
		if (rst) begin
			mtimecmp <= '1;
		end else if (timer_wr_en) begin
			if (ofs == MTIMECMP_LO)
				mtimecmp[DATA_WIDTH-1:0] <= HWDATA;
			else if (ofs == MTIMECMP_HI)
				mtimecmp[2*DATA_WIDTH-1:DATA_WIDTH] <= HWDATA;
		end
	end

	// interrupt lags the compare by one cycle
	always_ff @(posedge HCLK) begin
		if (rst)
			core_timer_int <= 1'b0;
		else
			core_timer_int <= (mtime >= mtimecmp);
	end

	always_comb begin
		case (ofs)
			MTIME_LO:    timer_rdata = mtime[DATA_WIDTH-1:0];
			MTIME_HI:    timer_rdata = mtime[2*DATA_WIDTH-1:DATA_WIDTH];
			MTIMECMP_LO: timer_rdata = mtimecmp[DATA_WIDTH-1:0];
			MTIMECMP_HI: timer_rdata = mtimecmp[2*DATA_WIDTH-1:DATA_WIDTH];
			default:     timer_rdata = '0;
		endcase
	end

endmodule

//--- logic/dtcm.sv
// 4 KB data memory, contents undefined after reset
// read is combinational, so it behaves as registers rather than a sync RAM
`timescale 1ns/1ps

module dtcm
	import soc_map_pkg::*;
(
	input  logic                      HCLK,
	input  logic                      dtcm_wr_en,
	input  logic [STRB_WIDTH-1:0]     dtcm_byte_strb,
	input  logic [DTCM_IDX_WIDTH-1:0] reg_word,
	input  logic [DATA_WIDTH-1:0]     HWDATA,
	output logic [DATA_WIDTH-1:0]     dtcm_rdata
);

	logic [DATA_WIDTH-1:0] mem [DTCM_WORDS];

	// one byte lane per strobe bit
	always_ff @(posedge HCLK) begin
		if (dtcm_wr_en) begin
			for (int i = 0; i < STRB_WIDTH; i++) begin
				if (dtcm_byte_strb[i])
					mem[reg_word][i*8 +: 8] <= HWDATA[i*8 +: 8];
			end
		end
	end

	assign dtcm_rdata = mem[reg_word];

	a_strb_nonzero: assert property (@(posedge HCLK)
		dtcm_wr_en |-> dtcm_byte_strb != '0)
		else $error("dtcm write with no byte lane selected");

endmodule

//--- logic/gpio.sv
// GPIO_IN is asynchronous, seen on reads 2 cycles after it changes
`timescale 1ns/1ps

module gpio
	import soc_map_pkg::*;
(
	input  logic                      HCLK,
	input  logic                      rst,
	input  logic                      gpio_wr_en,
	input  logic [DTCM_IDX_WIDTH-1:0] reg_word,
	input  logic [DATA_WIDTH-1:0]     HWDATA,
	input  logic [GPIO_WIDTH-1:0]     GPIO_IN,
	output logic [DATA_WIDTH-1:0]     gpio_rdata,
	output logic [GPIO_WIDTH-1:0]     GPIO_OUT
);

	logic [GPIO_WIDTH-1:0]     in_meta;
	logic [GPIO_WIDTH-1:0]     in_sync;
	logic [DTCM_IDX_WIDTH+1:0] ofs;

	assign ofs = {reg_word, 2'b00};

	always_ff @(posedge HCLK) begin
		if (rst) begin
			GPIO_OUT <= '0;
			in_meta <= '0;
			in_sync <= '0;
		end else begin
			// input register is read only
			if (gpio_wr_en && ofs == GPIO_OUT_OFS)
				GPIO_OUT <= HWDATA[GPIO_WIDTH-1:0];
			in_meta <= GPIO_IN;
			in_sync <= in_meta;
		end
	end

	always_comb begin
		case (ofs)
			GPIO_OUT_OFS: gpio_rdata = {{(DATA_WIDTH-GPIO_WIDTH){1'b0}}, GPIO_OUT};
			GPIO_IN_OFS:  gpio_rdata = {{(DATA_WIDTH-GPIO_WIDTH){1'b0}}, in_sync};
			default:      gpio_rdata = '0;
		endcase
	end

endmodule

//--- logic/krv_periph.sv
// AHB slave subsystem with dtcm, machine timer and gpio on one HCLK
// no wait states except the two-cycle ERROR response
`timescale 1ns/1ps

module krv_periph
	import ahb_pkg::*;
	import soc_map_pkg::*;
(
	input  logic                  HCLK,
	input  logic                  rst,
	input  logic                  HSEL,
	input  htrans_t               HTRANS,
	input  logic                  HWRITE,
	input  hsize_t                HSIZE,
	input  logic [ADDR_WIDTH-1:0] HADDR,
	input  logic [DATA_WIDTH-1:0] HWDATA,
	output logic                  HREADY,
	output hresp_t                HRESP,
	output logic [DATA_WIDTH-1:0] HRDATA,
	input  logic [GPIO_WIDTH-1:0] GPIO_IN,
	output logic [GPIO_WIDTH-1:0] GPIO_OUT,
	output logic                  core_timer_int
);

	logic                      dtcm_wr_en;
	logic [STRB_WIDTH-1:0]     dtcm_byte_strb;
	logic                      timer_wr_en;
	logic                      gpio_wr_en;
	logic [DTCM_IDX_WIDTH-1:0] reg_word;
	logic [DATA_WIDTH-1:0]     dtcm_rdata;
	logic [DATA_WIDTH-1:0]     timer_rdata;
	logic [DATA_WIDTH-1:0]     gpio_rdata;

	ahb_slave_ctrl u_ahb_slave_ctrl (
		.HCLK           (HCLK),
		.rst            (rst),
		.HSEL           (HSEL),
		.HTRANS         (HTRANS),
		.HWRITE         (HWRITE),
		.HSIZE          (HSIZE),
		.HADDR          (HADDR),
		.HREADY         (HREADY),
		.HRESP          (HRESP),
		.HRDATA         (HRDATA),
		.dtcm_wr_en     (dtcm_wr_en),
		.dtcm_byte_strb (dtcm_byte_strb),
		.timer_wr_en    (timer_wr_en),
		.gpio_wr_en     (gpio_wr_en),
		.reg_word       (reg_word),
		.dtcm_rdata     (dtcm_rdata),
		.timer_rdata    (timer_rdata),
		.gpio_rdata     (gpio_rdata)
	);

	dtcm u_dtcm (
		.HCLK           (HCLK),
		.dtcm_wr_en     (dtcm_wr_en),
		.dtcm_byte_strb (dtcm_byte_strb),
		.reg_word       (reg_word),
		.HWDATA         (HWDATA),
		.dtcm_rdata     (dtcm_rdata)
	);

	core_timer u_core_timer (
		.HCLK           (HCLK),
		.rst            (rst),
		.timer_wr_en    (timer_wr_en),
		.reg_word       (reg_word),
		.HWDATA         (HWDATA),
		.timer_rdata    (timer_rdata),
		.core_timer_int (core_timer_int)
	);

	gpio u_gpio (
		.HCLK       (HCLK),
		.rst        (rst),
		.gpio_wr_en (gpio_wr_en),
		.reg_word   (reg_word),
		.HWDATA     (HWDATA),
		.GPIO_IN    (GPIO_IN),
		.gpio_rdata (gpio_rdata),
		.GPIO_OUT   (GPIO_OUT)
	);

endmodule

//--- logic/soc_map_pkg.sv
// address map of the slave subsystem, every region is 4 KB
// register offsets are byte offsets inside a region

package soc_map_pkg;

	localparam int DATA_WIDTH     = 32;
	localparam int ADDR_WIDTH     = 32;
	localparam int STRB_WIDTH     = 4;
	localparam int GPIO_WIDTH     = 8;

	localparam logic [ADDR_WIDTH-1:0] DTCM_BASE  = 32'h2000_0000;
	localparam int DTCM_WORDS     = 1024;
	localparam int DTCM_IDX_WIDTH = 10;

	localparam logic [ADDR_WIDTH-1:0] TIMER_BASE  = 32'h0200_0000;
	localparam logic [ADDR_WIDTH-1:0] GPIO_BASE   = 32'h4000_0000;
	localparam logic [ADDR_WIDTH-1:0] REGION_SPAN = 32'h0000_1000;

	// machine timer registers
	localparam logic [DTCM_IDX_WIDTH+1:0] MTIME_LO    = 12'h000;
	localparam logic [DTCM_IDX_WIDTH+1:0] MTIME_HI    = 12'h004;
	localparam logic [DTCM_IDX_WIDTH+1:0] MTIMECMP_LO = 12'h008;
	localparam logic [DTCM_IDX_WIDTH+1:0] MTIMECMP_HI = 12'h00C;

	// gpio registers
	localparam logic [DTCM_IDX_WIDTH+1:0] GPIO_OUT_OFS = 12'h000;
	localparam logic [DTCM_IDX_WIDTH+1:0] GPIO_IN_OFS  = 12'h004;

	typedef enum logic [1:0] {
		REG_NONE  = 2'b00,
		REG_DTCM  = 2'b01,
		REG_TIMER = 2'b10,
		REG_GPIO  = 2'b11
	} region_t;

endpackage

//--- verif/tb_krv_periph.sv
// bus master testbench, single transfers plus write then read pairs
// dtcm words are only read back after this run has written them
`timescale 1ns/1ps

module tb_krv_periph
	import ahb_pkg::*;
	import soc_map_pkg::*;
();

	localparam int SEED          = 66186;
	localparam int RST_CYCLES    = 16;
	localparam int READY_TIMEOUT = 20;
	localparam int INT_TIMEOUT   = 50;
	localparam int N_WORD_OPS    = 300;

	logic                  HCLK;
	logic                  rst;
	logic                  HSEL;
	htrans_t               HTRANS;
	logic                  HWRITE;
	hsize_t                HSIZE;
	logic [ADDR_WIDTH-1:0] HADDR;
	logic [DATA_WIDTH-1:0] HWDATA;
	logic                  HREADY;
	hresp_t                HRESP;
	logic [DATA_WIDTH-1:0] HRDATA;
	logic [GPIO_WIDTH-1:0] GPIO_IN;
	logic [GPIO_WIDTH-1:0] GPIO_OUT;
	logic                  core_timer_int;

	// shadow model of the dtcm and the gpio output register
	logic [DATA_WIDTH-1:0] shadow_mem [DTCM_WORDS];
	bit                    shadow_vld [DTCM_WORDS];
	logic [GPIO_WIDTH-1:0] shadow_gpio;

	// expected read data, bit 32 set when the value is compared
	logic [DATA_WIDTH:0]   exp_q [$];
	logic [DATA_WIDTH:0]   exp_ent;
	logic                  rd_pend;

	krv_periph u_krv_periph (
		.HCLK           (HCLK),
		.rst            (rst),
		.HSEL           (HSEL),
		.HTRANS         (HTRANS),
		.HWRITE         (HWRITE),
		.HSIZE          (HSIZE),
		.HADDR          (HADDR),
		.HWDATA         (HWDATA),
		.HREADY         (HREADY),
		.HRESP          (HRESP),
		.HRDATA         (HRDATA),
		.GPIO_IN        (GPIO_IN),
		.GPIO_OUT       (GPIO_OUT),
		.core_timer_int (core_timer_int)
	);

	initial begin
		HCLK = 1'b0;
		forever #4 HCLK = ~HCLK;
	end

	task automatic report_failure(input string what);
		$display("%s at %0t ns", what, $time);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "value mismatch");
		end
	endtask

	// little endian lane merge, sub-word data sits on its own byte lanes
	function automatic logic [31:0] merge_write(input logic [31:0] old, input hsize_t size,
			input logic [1:0] lsb, input logic [31:0] wdata);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (size == WORD || (size == HALF && b[1] == lsb[1]) || (size == BYTE && b == lsb))
				res[b*8 +: 8] = wdata[b*8 +: 8];
		end
		return res;
	endfunction

	// data phase of a completed OKAY read is compared against the queue
	always @(negedge HCLK) begin
		if (rst) begin
			rd_pend = 1'b0;
		end else begin
			if (rd_pend && HREADY) begin
				rd_pend = 1'b0;
				if (HRESP == OKAY) begin
					if (exp_q.size() == 0)
						report_failure("read data returned with no expected value queued");
					exp_ent = exp_q.pop_front();
					if (exp_ent[DATA_WIDTH])
						check_value(HRDATA, exp_ent[DATA_WIDTH-1:0], "read data");
				end
			end
			if (HREADY && HSEL && (HTRANS == NONSEQ || HTRANS == SEQ) && !HWRITE)
				rd_pend = 1'b1;
		end
	end

	task automatic drive_address(input logic write, input hsize_t size, input logic [31:0] addr);
		int n;
		n = 0;
		@(posedge HCLK);
		#1;
		HSEL = 1'b1;
		HTRANS = NONSEQ;
		HWRITE = write;
		HSIZE = size;
		HADDR = addr;
		@(negedge HCLK);
		while (!HREADY) begin
			n++;
			if (n > READY_TIMEOUT)
				report_failure("timeout waiting for HREADY in an address phase");
			@(negedge HCLK);
		end
	endtask

	// returns at the falling edge of the cycle where HREADY ends the data phase
	task automatic finish_data_phase(output logic err, output int stalls,
			output logic [31:0] rdata);
		int n;
		n = 0;
		@(negedge HCLK);
		while (!HREADY) begin
			check_value(HRESP, ERROR, "HRESP while HREADY is low");
			n++;
			if (n > READY_TIMEOUT)
				report_failure("timeout waiting for HREADY in a data phase");
			@(negedge HCLK);
		end
		err = (HRESP == ERROR);
		stalls = n;
		rdata = HRDATA;
	endtask

	task automatic transfer(input logic write, input hsize_t size, input logic [31:0] addr,
			input logic [31:0] wdata, output logic err, output int stalls,
			output logic [31:0] rdata);
		drive_address(write, size, addr);
		@(posedge HCLK);
		#1;
		HSEL = 1'b0;
		HTRANS = IDLE;
		HWDATA = wdata;
		finish_data_phase(err, stalls, rdata);
	endtask

	task automatic write_ok(input hsize_t size, input logic [31:0] addr, input logic [31:0] wdata);
		logic        err;
		int          stalls;
		logic [31:0] rdata;
		transfer(1'b1, size, addr, wdata, err, stalls, rdata);
		check_value(err, 0, "OKAY response to write");
	endtask

	task automatic read_word(input logic [31:0] addr, input logic cmp, input logic [31:0] exp,
			output logic [31:0] rdata);
		logic err;
		int   stalls;
		exp_q.push_back({cmp, exp});
		transfer(1'b0, WORD, addr, '0, err, stalls, rdata);
		check_value(err, 0, "OKAY response to read");
	endtask

	task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp);
		logic [31:0] rdata;
		read_word(addr, 1'b1, exp, rdata);
	endtask

	// read address phase overlaps the write data phase
	task automatic write_then_read(input logic [31:0] addr, input logic [31:0] wdata);
		logic        err;
		int          stalls;
		logic [31:0] rdata;
		exp_q.push_back({1'b1, wdata});
		drive_address(1'b1, WORD, addr);
		@(posedge HCLK);
		#1;
		HWRITE = 1'b0;
		HWDATA = wdata;
		finish_data_phase(err, stalls, rdata);
		check_value(err, 0, "OKAY response to paired write");
		@(posedge HCLK);
		#1;
		HSEL = 1'b0;
		HTRANS = IDLE;
		finish_data_phase(err, stalls, rdata);
		check_value(err, 0, "OKAY response to paired read");
	endtask

	task automatic expect_error(input logic write, input hsize_t size, input logic [31:0] addr,
			input logic [31:0] wdata);
		logic        err;
		int          stalls;
		logic [31:0] rdata;
		transfer(write, size, addr, wdata, err, stalls, rdata);
		check_value(err, 1, "HRESP in second error cycle");
		check_value(stalls, 1, "cycles with HREADY low in error response");
	endtask

	task automatic wait_timer_int(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge HCLK);
		while (core_timer_int !== level) begin
			n++;
			if (n > limit)
				report_failure("core_timer_int did not reach the expected level");
			@(negedge HCLK);
		end
	endtask

	initial begin
		int          idx;
		int          op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] v;
		logic [31:0] t;
		hsize_t      size;
		void'($urandom(SEED));
		rst = 1'b1;
		HSEL = 1'b0;
		HTRANS = IDLE;
		HWRITE = 1'b0;
		HSIZE = WORD;
		HADDR = '0;
		HWDATA = '0;
		GPIO_IN = '0;
		shadow_gpio = '0;
		for (int i = 0; i < DTCM_WORDS; i++)
			shadow_vld[i] = 1'b0;
		repeat (RST_CYCLES) @(posedge HCLK);
		#1;
		rst = 1'b0;

		// reset state
		@(negedge HCLK);
		check_value(HREADY, 1, "HREADY after reset");
		check_value(HRESP, OKAY, "HRESP after reset");
		check_value(GPIO_OUT, 0, "GPIO_OUT after reset");
		check_value(core_timer_int, 0, "core_timer_int after reset");

		// random dtcm word traffic
		for (int i = 0; i < N_WORD_OPS; i++) begin
			idx = $urandom % DTCM_WORDS;
			op = $urandom % 3;
			addr = DTCM_BASE + 32'(idx) * 4;
			data = $urandom;
			if (op == 1 && shadow_vld[idx]) begin
				read_expect(addr, shadow_mem[idx]);
			end else begin
				if (op == 2)
					write_then_read(addr, data);
				else
					write_ok(WORD, addr, data);
				shadow_mem[idx] = merge_write(shadow_mem[idx], WORD, 2'b00, data);
				shadow_vld[idx] = 1'b1;
			end
		end

		// byte and half-word lanes
		for (int i = 0; i < 4; i++) begin
			idx = $urandom % DTCM_WORDS;
			addr = DTCM_BASE + 32'(idx) * 4;
			data = $urandom;
			write_ok(WORD, addr, data);
			shadow_mem[idx] = data;
			shadow_vld[idx] = 1'b1;
			for (int lane = 0; lane < 6; lane++) begin
				size = (lane < 4) ? BYTE : HALF;
				op = (lane < 4) ? lane : (lane - 4) * 2;
				data = $urandom;
				write_ok(size, addr + 32'(op), data);
				shadow_mem[idx] = merge_write(shadow_mem[idx], size, op[1:0], data);
				read_expect(addr, shadow_mem[idx]);
			end
		end

		// gpio output, ignored write to the input register, synchronized input
		data = $urandom;
		write_ok(WORD, GPIO_BASE + 32'(GPIO_OUT_OFS), data);
		shadow_gpio = data[GPIO_WIDTH-1:0];
		@(negedge HCLK);
		check_value(GPIO_OUT, shadow_gpio, "GPIO_OUT after write");
		read_expect(GPIO_BASE + 32'(GPIO_OUT_OFS), 32'(shadow_gpio));
		write_ok(WORD, GPIO_BASE + 32'(GPIO_IN_OFS), $urandom);
		read_expect(GPIO_BASE + 32'(GPIO_OUT_OFS), 32'(shadow_gpio));
		@(posedge HCLK);
		#1;
		GPIO_IN = GPIO_WIDTH'($urandom);
		repeat (3) @(posedge HCLK);
		read_expect(GPIO_BASE + 32'(GPIO_IN_OFS), 32'(GPIO_IN));

		// timer, v kept small so the low half never wraps
		v = $urandom & 32'h0FFF_FFFF;
		write_ok(WORD, TIMER_BASE + 32'(MTIME_HI), 32'h0);
		write_ok(WORD, TIMER_BASE + 32'(MTIME_LO), v);
		read_word(TIMER_BASE + 32'(MTIME_LO), 1'b0, 32'h0, t);
		check_value(t >= v && t <= v + 30, 1, "mtime window after write");
		read_expect(TIMER_BASE + 32'(MTIME_HI), 32'h0);
		write_ok(WORD, TIMER_BASE + 32'(MTIMECMP_HI), 32'h0);
		check_value(core_timer_int, 0, "core_timer_int before compare");
		write_ok(WORD, TIMER_BASE + 32'(MTIMECMP_LO), v + 20);
		read_expect(TIMER_BASE + 32'(MTIMECMP_LO), v + 20);
		wait_timer_int(1'b1, INT_TIMEOUT);
		write_ok(WORD, TIMER_BASE + 32'(MTIMECMP_HI), 32'hFFFF_FFFF);
		wait_timer_int(1'b0, 4);

		// error responses leave every target untouched
		// write data differs from what each target holds
		expect_error(1'b1, WORD, 32'h1000_0000, $urandom);
		expect_error(1'b0, WORD, 32'h6000_0040, $urandom);
		expect_error(1'b1, WORD, addr + 2, ~shadow_mem[idx]);
		expect_error(1'b1, BYTE, TIMER_BASE + 32'(MTIMECMP_LO), ~(v + 20));
		expect_error(1'b1, BYTE, GPIO_BASE + 32'(GPIO_OUT_OFS), {4{~shadow_gpio}});
		expect_error(1'b1, WORD, GPIO_BASE + 32'h10, $urandom);
		read_expect(addr, shadow_mem[idx]);
		read_expect(GPIO_BASE + 32'(GPIO_OUT_OFS), 32'(shadow_gpio));
		read_expect(TIMER_BASE + 32'(MTIMECMP_LO), v + 20);

		@(negedge HCLK);
		if (exp_q.size() != 0) begin
			report_failure("expected reads left without a data phase");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

//--- vlog.f
logic/ahb_pkg.sv
logic/soc_map_pkg.sv
logic/ahb_slave_ctrl.sv
logic/dtcm.sv
logic/core_timer.sv
logic/gpio.sv
logic/krv_periph.sv
verif/tb_krv_periph.sv
